/* rtl/pktgen_pkg.sv */
// shared types, register map and frame constants for the packet generator
// imported by every block of the design

package pktgen_pkg;

    //////////////////////////////////////////////////////////////////////
    // field types

    typedef logic [47:0]        mac_addr_t;
    typedef logic [15:0]        eth_type_t;
    typedef logic [31:0]        pkt_id_t;
    typedef logic [31:0]        pkt_count_t;
    // signed 16.16 token bucket
    typedef logic signed [31:0] shaper_val_t;
    // unsigned 15.16 drain per cycle
    typedef logic [30:0]        shaper_dec_t;
    typedef logic [3:0]         reg_addr_t;
    typedef logic [31:0]        reg_data_t;

    // generator FSM, codes are visible in the status register
    typedef enum logic [1:0] {
        gen_idle       = 2'd0,
        gen_wait_grant = 2'd1,
        gen_launch     = 2'd2,
        gen_wait_sent  = 2'd3
    } gen_state_t;

    //////////////////////////////////////////////////////////////////////
    // frame layout and register map

    // dest mac + src mac + ethertype
    localparam int HEADER_BYTES = 14;

    // config, read back as written
    localparam reg_addr_t REG_CTRL         = 4'd0;
    localparam reg_addr_t REG_NUM_PACKETS  = 4'd1;
    localparam reg_addr_t REG_SHAPER_DEC   = 4'd2;
    localparam reg_addr_t REG_ETH_TYPE     = 4'd3;
    localparam reg_addr_t REG_MAC_HI       = 4'd4;
    localparam reg_addr_t REG_MAC_LO       = 4'd5;
    // status, read only
    localparam reg_addr_t REG_STATUS       = 4'd8;
    localparam reg_addr_t REG_REMAINING    = 4'd9;
    localparam reg_addr_t REG_SHAPER_ACCUM = 4'd10;
    localparam reg_addr_t REG_TX_CNT_LO    = 4'd11;
    localparam reg_addr_t REG_TX_CNT_HI    = 4'd12;

endpackage

/* rtl/pktgen_ifc.sv */
// interfaces between register file, control FSM and frame serializer
// cfg carries software settings and status, frame_req hands one frame over
`timescale 1ns/1ps

interface pktgen_cfg_ifc import pktgen_pkg::*; ();
    // settings from the register file
    logic        start;
    logic        continuous;
    pkt_count_t  num_packets;
    eth_type_t   eth_type;
    mac_addr_t   mac_dest;
    // status back from the FSM
    gen_state_t  state;
    pkt_count_t  remaining;
    logic [63:0] tx_cnt;

    modport regs (output start, continuous, num_packets, eth_type, mac_dest,
                  input state, remaining, tx_cnt);
    modport ctrl (input start, continuous, num_packets, eth_type, mac_dest,
                  output state, remaining, tx_cnt);
endinterface

interface frame_req_ifc import pktgen_pkg::*; ();
    logic      valid;
    logic      ready;
    pkt_id_t   packet_id;
    mac_addr_t mac_dest;
    eth_type_t eth_type;
    // one cycle pulse on the last byte transfer
    logic      sent;

    modport ctrl (output valid, packet_id, mac_dest, eth_type, input ready, sent);
    modport tx (input valid, packet_id, mac_dest, eth_type, output ready, sent);
endinterface

/* rtl/pktgen_regs.sv */
// avalon-mm register file of the packet generator
// holds the config words, makes the start strobe and returns status on reads
`timescale 1ns/1ps

module pktgen_regs import pktgen_pkg::*; (
    input  logic         clk_ifc_avmm,
    input  logic         rst_n,
    input  reg_addr_t    avmm_address,
    input  logic         avmm_write,
    input  reg_data_t    avmm_writedata,
    input  logic         avmm_read,
    output reg_data_t    avmm_readdata,
    output logic         avmm_readdatavalid,
    pktgen_cfg_ifc.regs  cfg,
    output shaper_dec_t  shaper_dec,
    input  shaper_val_t  shaper_val
);

    logic       continuous;
    logic       start_q;
    pkt_count_t num_packets;
    shaper_dec_t dec_q;
    eth_type_t  eth_type;
    mac_addr_t  mac_dest;
    reg_data_t  rd_mux;
    reg_data_t  status_word;

    //////////////////////////////////////////////////////////////////////
    // write side

    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            continuous  <= 1'b0;
            start_q     <= 1'b0;
            num_packets <= '0;
            dec_q       <= '0;
            eth_type    <= '0;
            mac_dest    <= '0;
        end else begin
            // start only lives for one cycle
            start_q <= 1'b0;
            if (avmm_write) begin
                case (avmm_address)
                    REG_CTRL: begin
                        continuous <= avmm_writedata[1];
                        start_q    <= avmm_writedata[0];
                    end
                    REG_NUM_PACKETS: num_packets     <= avmm_writedata;
                    REG_SHAPER_DEC:  dec_q           <= avmm_writedata[30:0];
                    REG_ETH_TYPE:    eth_type        <= avmm_writedata[15:0];
                    REG_MAC_HI:      mac_dest[47:32] <= avmm_writedata[15:0];
                    REG_MAC_LO:      mac_dest[31:0]  <= avmm_writedata;
                    default: ;
                endcase
            end
        end
    end

    // strobe is one cycle behind the write, so a combined
    // start + continuous write is seen with the new mode
    assign cfg.start       = start_q;
    assign cfg.continuous  = continuous;
    assign cfg.num_packets = num_packets;
    assign cfg.eth_type    = eth_type;
    assign cfg.mac_dest    = mac_dest;
    assign shaper_dec      = dec_q;

    //////////////////////////////////////////////////////////////////////
    // read side

    // active flag on top, fsm code in the low byte
    assign status_word = {cfg.state != gen_idle, 23'd0, 6'd0, cfg.state};

    always_comb begin
        case (avmm_address)
            REG_CTRL:         rd_mux = {30'd0, continuous, 1'b0};
            REG_NUM_PACKETS:  rd_mux = num_packets;
            REG_SHAPER_DEC:   rd_mux = {1'b0, dec_q};
            REG_ETH_TYPE:     rd_mux = {16'd0, eth_type};
            REG_MAC_HI:       rd_mux = {16'd0, mac_dest[47:32]};
            REG_MAC_LO:       rd_mux = mac_dest[31:0];
            REG_STATUS:       rd_mux = status_word;
            REG_REMAINING:    rd_mux = cfg.remaining;
            REG_SHAPER_ACCUM: rd_mux = reg_data_t'(shaper_val);
            REG_TX_CNT_LO:    rd_mux = cfg.tx_cnt[31:0];
            REG_TX_CNT_HI:    rd_mux = cfg.tx_cnt[63:32];
            default:          rd_mux = '0;
        endcase
    end

    // fixed one cycle read latency
    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            avmm_readdatavalid <= 1'b0;
        end else begin
            avmm_readdatavalid <= avmm_read;
        end
    end

    always_ff @(posedge clk_ifc_avmm) begin
        if (avmm_read) begin
            avmm_readdata <= rd_mux;
        end
    end

endmodule

/* rtl/pktgen_ctrl.sv */
// sequencing FSM of the packet generator
// counts packets, hands frame requests to the serializer, tracks sent frames
`timescale 1ns/1ps

module pktgen_ctrl import pktgen_pkg::*; #(
    parameter int PAYLOAD_WORDS = 10
) (
    input  logic        clk_ifc_avmm,
    input  logic        rst_n,
    pktgen_cfg_ifc.ctrl cfg,
    frame_req_ifc.ctrl  req,
    input  logic        grant,
    output gen_state_t  state
);

    // an empty payload would leave the frame without an id
    if (PAYLOAD_WORDS < 1) begin : gen_bad_payload
        $error("PAYLOAD_WORDS must be at least 1");
    end

    gen_state_t  state_q;
    pkt_count_t  remaining;
    pkt_id_t     packet_id;
    logic [63:0] tx_cnt;
    logic        cont_q;
    logic        req_valid;

    //////////////////////////////////////////////////////////////////////
    // FSM

    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            state_q   <= gen_idle;
            remaining <= '0;
            packet_id <= '0;
            tx_cnt    <= '0;
            cont_q    <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            case (state_q)
                gen_idle: begin
                    // track mode until start
                    packet_id <= '0;
                    cont_q    <= cfg.continuous;
                    req_valid <= 1'b0;
                    if (cfg.start) begin
                        // count taken with the start, idle keeps the final remaining
                        remaining <= cfg.num_packets;
                        tx_cnt    <= '0;
                        state_q   <= gen_wait_grant;
                    end
                end
                gen_wait_grant: begin
                    // shaper only applies in continuous mode
                    if (req.ready && (grant || !cont_q)) begin
                        req_valid <= 1'b1;
                        state_q   <= gen_launch;
                    end
                end
                gen_launch: begin
                    // frame taken this cycle
                    req_valid <= 1'b0;
                    packet_id <= packet_id + 1'b1;
                    remaining <= cont_q ? '0 : remaining - 1'b1;
                    state_q   <= gen_wait_sent;
                end
                gen_wait_sent: begin
                    if (req.sent) begin
                        // saturate once the top bit is reached
                        if (!tx_cnt[63]) begin
                            tx_cnt <= tx_cnt + 1'b1;
                        end
                        // live bit, so clearing it ends continuous mode
                        if (remaining != '0 || cfg.continuous) begin
                            state_q <= gen_wait_grant;
                        end else begin
                            state_q <= gen_idle;
                        end
                    end
                end
                default: state_q <= gen_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs

    // ids start at 1, counter bumps after the launch
    assign req.valid     = req_valid;
    assign req.packet_id = packet_id + 1'b1;
    assign req.mac_dest  = cfg.mac_dest;
    assign req.eth_type  = cfg.eth_type;

    assign cfg.state     = state_q;
    assign cfg.remaining = remaining;
    assign cfg.tx_cnt    = tx_cnt;
    assign state         = state_q;

endmodule

/* rtl/rate_shaper.sv */
// token bucket rate shaper for continuous mode
// each launch charges the frame cost, the bucket drains by shaper_dec per cycle
`timescale 1ns/1ps

module rate_shaper import pktgen_pkg::*; #(
    parameter int PAYLOAD_WORDS = 10
) (
    input  logic        clk_ifc_avmm,
    input  logic        rst_n,
    input  gen_state_t  state,
    input  shaper_dec_t shaper_dec,
    output shaper_val_t shaper_val,
    output logic        grant
);

    // frame cost in bytes, 16.16 fixed point
    localparam shaper_val_t FRAME_COST =
        shaper_val_t'((HEADER_BYTES + 4 * PAYLOAD_WORDS) * 65536);

    shaper_val_t accum;
    shaper_val_t dec_ext;

    assign dec_ext = shaper_val_t'({1'b0, shaper_dec});

    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            accum <= '0;
        end else if (state == gen_idle) begin
            accum <= '0;
        end else if (state == gen_launch) begin
            accum <= accum + FRAME_COST - dec_ext;
        end else if (!(accum[31] && !accum[30])) begin
            // hold deep negative values instead of wrapping
            accum <= accum - dec_ext;
        end
    end

    assign shaper_val = accum;
    // drained bucket grants a launch
    // zero decrement turns the shaper off
    assign grant = accum[31] || (shaper_dec == '0);

endmodule

/* rtl/frame_tx.sv */
// byte serializer for one ethernet test frame
// header msb first, then the packet id repeated over the payload words
`timescale 1ns/1ps

module frame_tx import pktgen_pkg::*; #(
    parameter int        PAYLOAD_WORDS = 10,
    parameter mac_addr_t MAC_ADDR_SRC  = 48'haa_aa_aa_aa_bb_aa
) (
    input  logic       clk_ifc_avmm,
    input  logic       rst_n,
    frame_req_ifc.tx   req,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready,
    output logic       tx_last
);

    localparam int FRAME_BYTES = HEADER_BYTES + 4 * PAYLOAD_WORDS;
    localparam int IDX_W       = $clog2(FRAME_BYTES);

    typedef logic [IDX_W-1:0] byte_idx_t;

    localparam byte_idx_t LAST_IDX = byte_idx_t'(FRAME_BYTES - 1);

    logic                      busy;
    byte_idx_t                 byte_idx;
    byte_idx_t                 pay_off;
    mac_addr_t                 mac_dest_q;
    eth_type_t                 eth_type_q;
    pkt_id_t                   packet_id_q;
    logic [8*HEADER_BYTES-1:0] header;
    logic                      accept;
    logic                      xfer;

    //////////////////////////////////////////////////////////////////////
    // handshakes

    // one frame in flight at a time
    assign req.ready = !busy;
    assign accept    = req.valid && req.ready;
    assign xfer      = tx_valid && tx_ready;

    //////////////////////////////////////////////////////////////////////
    // byte counter

    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            byte_idx <= '0;
        end else if (accept) begin
            busy     <= 1'b1;
            byte_idx <= '0;
        end else if (xfer) begin
            if (byte_idx == LAST_IDX) begin
                busy <= 1'b0;
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    // frame fields, taken on accept
    always_ff @(posedge clk_ifc_avmm) begin
        if (accept) begin
            mac_dest_q  <= req.mac_dest;
            eth_type_q  <= req.eth_type;
            packet_id_q <= req.packet_id;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // byte mux

    assign header  = {mac_dest_q, MAC_ADDR_SRC, eth_type_q};
    // offset into the payload, low two bits pick the id byte
    assign pay_off = byte_idx - byte_idx_t'(HEADER_BYTES);

    always_comb begin
        if (int'(byte_idx) < HEADER_BYTES) begin
            tx_data = header[8 * (HEADER_BYTES - 1 - int'(byte_idx)) +: 8];
        end else begin
            tx_data = packet_id_q[8 * (3 - int'(pay_off[1:0])) +: 8];
        end
    end

    // index only moves on a transfer, so data holds under back-pressure
    assign tx_valid = busy;
    assign tx_last  = busy && (byte_idx == LAST_IDX);
    assign req.sent = xfer && tx_last;

endmodule

/* rtl/pktgen_top.sv */
// top level of the ethernet test frame generator
// avalon-mm slave for control, byte stream with valid/ready out
`timescale 1ns/1ps

module pktgen_top import pktgen_pkg::*; #(
    parameter int        PAYLOAD_WORDS = 10,
    parameter mac_addr_t MAC_ADDR_SRC  = 48'haa_aa_aa_aa_bb_aa
) (
    input  logic       clk_ifc_avmm,
    input  logic       rst_n,
    // avalon-mm slave
    input  reg_addr_t  avmm_address,
    input  logic       avmm_write,
    input  reg_data_t  avmm_writedata,
    input  logic       avmm_read,
    output reg_data_t  avmm_readdata,
    output logic       avmm_readdatavalid,
    // frame byte stream
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready,
    output logic       tx_last
);

    shaper_dec_t shaper_dec;
    shaper_val_t shaper_val;
    gen_state_t  state;
    logic        grant;

    pktgen_cfg_ifc cfg_if ();
    frame_req_ifc  req_if ();

    pktgen_regs u_regs (
        .clk_ifc_avmm       (clk_ifc_avmm),
        .rst_n              (rst_n),
        .avmm_address       (avmm_address),
        .avmm_write         (avmm_write),
        .avmm_writedata     (avmm_writedata),
        .avmm_read          (avmm_read),
        .avmm_readdata      (avmm_readdata),
        .avmm_readdatavalid (avmm_readdatavalid),
        .cfg                (cfg_if.regs),
        .shaper_dec         (shaper_dec),
        .shaper_val         (shaper_val)
    );

    pktgen_ctrl #(.PAYLOAD_WORDS(PAYLOAD_WORDS)) u_ctrl (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_n        (rst_n),
        .cfg          (cfg_if.ctrl),
        .req          (req_if.ctrl),
        .grant        (grant),
        .state        (state)
    );

    rate_shaper #(.PAYLOAD_WORDS(PAYLOAD_WORDS)) u_shaper (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_n        (rst_n),
        .state        (state),
        .shaper_dec   (shaper_dec),
        .shaper_val   (shaper_val),
        .grant        (grant)
    );

    frame_tx #(
        .PAYLOAD_WORDS (PAYLOAD_WORDS),
        .MAC_ADDR_SRC  (MAC_ADDR_SRC)
    ) u_frame_tx (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_n        (rst_n),
        .req          (req_if.tx),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_last      (tx_last)
    );

endmodule

/* test/tb_pktgen.sv */
// testbench for the packet generator, drives the avalon-mm port and checks
// every output byte against a model of the test frames
`timescale 1ns/1ps

module tb_pktgen import pktgen_pkg::*; ();

    localparam int          PAYLOAD_WORDS   = 4;
    localparam int          FRAME_BYTES     = HEADER_BYTES + 4 * PAYLOAD_WORDS;
    localparam logic [47:0] SRC_MAC         = 48'haa_aa_aa_aa_bb_aa;
    localparam int          SHAPER_WINDOW   = 1500;
    // about 42 frames worst case over all tests, 20 cycles a byte
    localparam int          WATCHDOG_CYCLES = 42 * FRAME_BYTES * 20 + 5000;

    logic       clk_ifc_avmm;
    logic       rst_n;
    reg_addr_t  avmm_address;
    logic       avmm_write;
    reg_data_t  avmm_writedata;
    logic       avmm_read;
    reg_data_t  avmm_readdata;
    logic       avmm_readdatavalid;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready = 1'b1;
    logic       tx_last;

    integer     seed         = 32'hdf44;
    // separate stream so back-pressure does not shift the test values
    integer     ready_seed   = 32'hdf44 ^ 32'h0000_5a5a;
    logic       random_ready = 1'b0;
    logic [7:0] got_bytes[$];
    logic [7:0] exp_bytes[$];
    int         frames_done  = 0;
    // byte position inside the current frame
    int         frame_pos    = 0;
    int         errors       = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;

    pktgen_top #(.PAYLOAD_WORDS(PAYLOAD_WORDS)) u_dut (
        .clk_ifc_avmm       (clk_ifc_avmm),
        .rst_n              (rst_n),
        .avmm_address       (avmm_address),
        .avmm_write         (avmm_write),
        .avmm_writedata     (avmm_writedata),
        .avmm_read          (avmm_read),
        .avmm_readdata      (avmm_readdata),
        .avmm_readdatavalid (avmm_readdatavalid),
        .tx_data            (tx_data),
        .tx_valid           (tx_valid),
        .tx_ready           (tx_ready),
        .tx_last            (tx_last)
    );

    initial begin
        clk_ifc_avmm = 1'b0;
        forever #5 clk_ifc_avmm = ~clk_ifc_avmm;
    end

    // sink side, ready held high unless a test asks for stalls
    always @(posedge clk_ifc_avmm) begin : ready_drive
        logic [31:0] r;
        r = $random(ready_seed);
        if (random_ready) begin
            tx_ready <= r[0];
        end else begin
            tx_ready <= 1'b1;
        end
    end

    // byte collector, counts a frame on each last byte
    always @(posedge clk_ifc_avmm) begin : collect
        logic exp_last;
        if (rst_n && tx_valid && tx_ready) begin
            got_bytes.push_back(tx_data);
            // last flag belongs on the final byte of each frame only
            exp_last = (frame_pos == FRAME_BYTES - 1);
            if (tx_last !== exp_last) begin
                report_mismatch("tx_last", {31'd0, exp_last}, {31'd0, tx_last});
            end
            if (exp_last) begin
                frame_pos = 0;
            end else begin
                frame_pos++;
            end
            if (tx_last) begin
                frames_done <= frames_done + 1;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_ifc_avmm);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // reporting and bus access

    task automatic report_mismatch(input string name, input reg_data_t exp,
                                   input reg_data_t got);
        $display("mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - err_before);
        end
    endtask

    // write lands on the second edge
    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk_ifc_avmm);
        avmm_address   <= addr;
        avmm_writedata <= data;
        avmm_write     <= 1'b1;
        @(posedge clk_ifc_avmm);
        avmm_write     <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        int waited;
        @(posedge clk_ifc_avmm);
        avmm_address <= addr;
        avmm_read    <= 1'b1;
        @(posedge clk_ifc_avmm);
        avmm_read    <= 1'b0;
        waited = 0;
        data   = '0;
        do begin
            @(posedge clk_ifc_avmm);
            waited++;
        end while (!avmm_readdatavalid && waited < 8);
        if (avmm_readdatavalid) begin
            data = avmm_readdata;
            // valid is due one cycle after the read
            if (waited != 1) begin
                report_failure($sformatf("readdatavalid %0d cycles late for address %0d",
                                         waited - 1, addr));
            end
        end else begin
            report_failure($sformatf("no readdatavalid for address %0d", addr));
        end
    endtask

    task automatic expect_reg(input reg_addr_t addr, input reg_data_t exp, input string name);
        reg_data_t got;
        read_reg(addr, got);
        if (got !== exp) begin
            report_mismatch(name, exp, got);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // frame model and waits

    // readable bits of each config register
    function automatic reg_data_t reg_mask(input int addr);
        case (addr)
            0:       return 32'h0000_0002;
            1, 5:    return 32'hffff_ffff;
            2:       return 32'h7fff_ffff;
            3, 4:    return 32'h0000_ffff;
            default: return 32'h0000_0000;
        endcase
    endfunction

    // header msb first, then the id once per payload word
    task automatic add_frame(input logic [47:0] mac, input logic [15:0] eth, input pkt_id_t id);
        for (int i = 5; i >= 0; i--) exp_bytes.push_back(mac[8*i +: 8]);
        for (int i = 5; i >= 0; i--) exp_bytes.push_back(SRC_MAC[8*i +: 8]);
        exp_bytes.push_back(eth[15:8]);
        exp_bytes.push_back(eth[7:0]);
        for (int w = 0; w < PAYLOAD_WORDS; w++) begin
            for (int i = 3; i >= 0; i--) exp_bytes.push_back(id[8*i +: 8]);
        end
    endtask

    task automatic compare_stream();
        int i;
        if (got_bytes.size() != exp_bytes.size()) begin
            report_mismatch("tx byte count", exp_bytes.size(), got_bytes.size());
        end
        for (i = 0; i < got_bytes.size() && i < exp_bytes.size(); i++) begin
            if (got_bytes[i] !== exp_bytes[i]) begin
                report_mismatch($sformatf("tx_data[%0d]", i), {24'd0, exp_bytes[i]},
                                {24'd0, got_bytes[i]});
                break;
            end
        end
    endtask

    task automatic wait_frames(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (frames_done < target && cycles < limit) begin
            @(posedge clk_ifc_avmm);
            cycles++;
        end
        if (frames_done < target) begin
            report_failure($sformatf("timed out waiting for frame %0d", target));
        end
    endtask

    // poll status until the FSM is back in idle
    task automatic wait_idle();
        reg_data_t st;
        int        tries;
        tries = 0;
        do begin
            read_reg(REG_STATUS, st);
            tries++;
        end while (st != 0 && tries < 200);
        if (st != 0) begin
            report_failure("generator did not return to idle");
        end
    endtask

    task automatic program_header(output logic [47:0] mac, output logic [15:0] eth);
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        r_hi = $random(seed);
        r_lo = $random(seed);
        mac  = {r_hi[15:0], r_lo};
        eth  = r_hi[31:16];
        write_reg(REG_MAC_HI, {16'd0, mac[47:32]});
        write_reg(REG_MAC_LO, mac[31:0]);
        write_reg(REG_ETH_TYPE, {16'd0, eth});
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests

    task automatic test_regs();
        reg_data_t wr_val [6];
        reg_addr_t unused [5] = '{4'd6, 4'd7, 4'd13, 4'd14, 4'd15};
        int        err_before;
        err_before = errors;
        for (int a = 0; a < 6; a++) begin
            wr_val[a] = $random(seed);
            // keep the start bit clear
            if (a == 0) wr_val[a][0] = 1'b0;
            write_reg(reg_addr_t'(a), wr_val[a]);
        end
        for (int u = 0; u < 5; u++) write_reg(unused[u], $random(seed));
        for (int a = 0; a < 6; a++) begin
            expect_reg(reg_addr_t'(a), wr_val[a] & reg_mask(a), $sformatf("reg %0d", a));
        end
        for (int u = 0; u < 5; u++) begin
            expect_reg(unused[u], 32'h0, $sformatf("reg %0d", unused[u]));
        end
        write_reg(REG_CTRL, 32'h0);
        finish_test("register readback", err_before);
    endtask

    task automatic test_burst(input string name, input logic stalls);
        logic [47:0] mac;
        logic [15:0] eth;
        int          n;
        int          base;
        int          err_before;
        err_before = errors;
        n = 1 + int'($unsigned($random(seed)) % 5);
        program_header(mac, eth);
        got_bytes.delete();
        exp_bytes.delete();
        for (int k = 1; k <= n; k++) add_frame(mac, eth, pkt_id_t'(k));
        base = frames_done;
        random_ready = stalls;
        write_reg(REG_NUM_PACKETS, n);
        write_reg(REG_CTRL, 32'h1);
        wait_frames(base + n, n * FRAME_BYTES * 20 + 200);
        random_ready = 1'b0;
        wait_idle();
        if (frames_done - base != n) begin
            report_mismatch("frame count", n, frames_done - base);
        end
        compare_stream();
        expect_reg(REG_STATUS, 32'h0, "REG_STATUS");
        // burst counted all the way down
        expect_reg(REG_REMAINING, 32'h0, "REG_REMAINING");
        expect_reg(REG_TX_CNT_LO, n, "REG_TX_CNT_LO");
        finish_test(name, err_before);
    endtask

    task automatic test_continuous();
        logic [47:0] mac;
        logic [15:0] eth;
        int          base;
        int          at_clear;
        int          total;
        int          err_before;
        err_before = errors;
        program_header(mac, eth);
        got_bytes.delete();
        exp_bytes.delete();
        base = frames_done;
        // zero drain, shaper never holds a launch
        write_reg(REG_SHAPER_DEC, 32'h0);
        write_reg(REG_CTRL, 32'h3);
        wait_frames(base + 5, 5 * FRAME_BYTES * 20 + 200);
        write_reg(REG_CTRL, 32'h0);
        @(posedge clk_ifc_avmm);
        at_clear = frames_done - base;
        wait_idle();
        total = frames_done - base;
        if (total - at_clear > 1) begin
            report_failure($sformatf("%0d frames after continuous cleared", total - at_clear));
        end
        for (int k = 1; k <= total; k++) add_frame(mac, eth, pkt_id_t'(k));
        compare_stream();
        expect_reg(REG_TX_CNT_LO, total, "REG_TX_CNT_LO");
        finish_test("continuous", err_before);
    endtask

    task automatic test_shaper();
        int     d;
        int     f;
        int     base;
        int     err_before;
        longint sent_cost;
        longint budget;
        err_before = errors;
        d = 10000 + int'($unsigned($random(seed)) % 16384);
        write_reg(REG_SHAPER_DEC, d);
        base = frames_done;
        write_reg(REG_CTRL, 32'h3);
        repeat (SHAPER_WINDOW) @(posedge clk_ifc_avmm);
        f = frames_done - base;
        write_reg(REG_CTRL, 32'h0);
        wait_idle();
        // bucket allows two frames of burst on top of the drain
        sent_cost = longint'(f) * FRAME_BYTES * 65536;
        budget    = longint'(d) * SHAPER_WINDOW + 2 * FRAME_BYTES * 65536;
        if (sent_cost > budget) begin
            report_failure($sformatf("%0d frames in %0d cycles exceed decrement %0d",
                                     f, SHAPER_WINDOW, d));
        end
        finish_test("shaper limit", err_before);
    endtask

    initial begin : main
        rst_n          = 1'b0;
        avmm_address   = '0;
        avmm_write     = 1'b0;
        avmm_writedata = '0;
        avmm_read      = 1'b0;
        repeat (4) @(posedge clk_ifc_avmm);
        rst_n <= 1'b1;
        @(posedge clk_ifc_avmm);
        test_regs();
        test_burst("burst", 1'b0);
        test_burst("back-pressure", 1'b1);
        test_continuous();
        test_shaper();
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/pktgen_pkg.sv
rtl/pktgen_ifc.sv
rtl/pktgen_regs.sv
rtl/pktgen_ctrl.sv
rtl/rate_shaper.sv
rtl/frame_tx.sv
rtl/pktgen_top.sv
test/tb_pktgen.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_pktgen
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

# build, run, then look for the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
